// ==== design/stripe_pkg.sv ====
package stripe_pkg;

  // ------------------------------
  // geometry
  // ------------------------------

  // bank count has to stay a power of two so the word index splits cleanly
  localparam int num_banks   = 4;
  localparam int bank_sel_w  = $clog2(num_banks);
  localparam int addr_w      = 12;
  localparam int data_w      = 32;
  localparam int strb_w      = data_w / 8;
  localparam int word_off_w  = $clog2(strb_w);
  localparam int id_w        = 4;
  // a bank sees the manager address with the bank select bits removed
  localparam int bank_addr_w = addr_w - bank_sel_w;
  localparam int word_idx_w  = addr_w - word_off_w;
  localparam int bank_word_w = bank_addr_w - word_off_w;
  localparam int bank_depth  = 2 ** bank_word_w;

  // ------------------------------
  // AXI codes
  // ------------------------------

  // awsize for a beat that fills the whole data bus
  localparam logic [2:0] full_size   = 3'(word_off_w);
  localparam logic [1:0] burst_fixed = 2'b00;
  localparam logic [1:0] burst_incr  = 2'b01;
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // ------------------------------
  // channel payloads
  // ------------------------------

  typedef logic [bank_sel_w-1:0] bank_sel_t;

  typedef struct packed {
    logic [id_w-1:0]   id;
    logic [addr_w-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
    logic [1:0]        burst;
  } axi_aw_t;

  typedef struct packed {
    logic [id_w-1:0]        id;
    logic [bank_addr_w-1:0] addr;
    logic [7:0]             len;
    logic [2:0]             size;
    logic [1:0]             burst;
  } bank_aw_t;

  typedef struct packed {
    logic [data_w-1:0] data;
    logic [strb_w-1:0] strb;
    logic              last;
  } axi_w_t;

  typedef struct packed {
    logic [id_w-1:0] id;
    logic [1:0]      resp;
  } axi_b_t;

endpackage

// ==== design/skid_buffer.sv ====
`timescale 1ns/100ps

module skid_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  // second slot, filled only when the output stalls while a beat arrives
  logic     skid_valid;
  payload_t skid_data;

  // in_ready comes straight from a flop so the upstream path stays short
  assign in_ready = !skid_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_ready || !out_valid) begin
      // the output slot is free or drains this cycle, so refill it
      out_valid  <= skid_valid || in_valid;
      skid_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_ready || !out_valid) begin
      // the parked beat is older and must leave first
      out_data <= skid_valid ? skid_data : in_data;
    end else if (in_valid && in_ready) begin
      skid_data <= in_data;
    end
  end

  // a stalled output must not change under the consumer
  a_out_stable : assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// ==== design/stripe_addr_split.sv ====
`timescale 1ns/100ps

module stripe_addr_split (
  input  logic [stripe_pkg::addr_w-1:0]                                   addr,
  input  logic [7:0]                                                      len,
  output stripe_pkg::bank_sel_t                                           start_idx,
  output stripe_pkg::bank_sel_t                                           end_idx,
  output logic [stripe_pkg::num_banks-1:0]                                sub_valid,
  output logic [stripe_pkg::num_banks-1:0][stripe_pkg::bank_addr_w-1:0] sub_addr,
  output logic [stripe_pkg::num_banks-1:0][7:0]                           sub_len
);
  import stripe_pkg::*;

  logic [word_idx_w-1:0] word_idx;

  assign word_idx = addr[addr_w-1:word_off_w];

  // beat k of the burst lands in bank (s + k) mod num_banks
  assign start_idx = word_idx[bank_sel_w-1:0];
  // the last beat sits len banks past the first, wrapping round the stripe
  assign end_idx   = start_idx + bank_sel_t'(len);

  always_comb begin
    bank_sel_t             offset;
    logic [word_idx_w-1:0] first_word;

    for (int i = 0; i < num_banks; i++) begin
      // offset is the beat number of this bank's first beat
      offset     = bank_sel_t'(i) - start_idx;
      first_word = word_idx + word_idx_w'(offset);
      // a bank joins only if the burst is long enough to reach it
      sub_valid[i] = 8'(offset) <= len;
      // every num_banks-th beat after the first belongs to the same bank
      sub_len[i]   = sub_valid[i] ? (len - 8'(offset)) >> bank_sel_w : 8'd0;
      // drop the bank select bits and turn the bank word back into bytes
      sub_addr[i]  = {first_word[word_idx_w-1:bank_sel_w], {word_off_w{1'b0}}};
    end
  end

endmodule

// ==== design/stripe_wr.sv ====
`timescale 1ns/100ps

module stripe_wr (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  stripe_pkg::axi_aw_t                                 aw,
  input  logic                                                aw_valid,
  output logic                                                aw_ready,
  input  stripe_pkg::axi_w_t                                  w,
  input  logic                                                w_valid,
  output logic                                                w_ready,
  output stripe_pkg::axi_b_t                                  b,
  output logic                                                b_valid,
  input  logic                                                b_ready,
  output stripe_pkg::bank_aw_t [stripe_pkg::num_banks-1:0]    bank_aw,
  output logic [stripe_pkg::num_banks-1:0]                    bank_aw_valid,
  input  logic [stripe_pkg::num_banks-1:0]                    bank_aw_ready,
  output stripe_pkg::axi_w_t [stripe_pkg::num_banks-1:0]      bank_w,
  output logic [stripe_pkg::num_banks-1:0]                    bank_w_valid,
  input  logic [stripe_pkg::num_banks-1:0]                    bank_w_ready,
  input  stripe_pkg::axi_b_t [stripe_pkg::num_banks-1:0]      bank_b,
  input  logic [stripe_pkg::num_banks-1:0]                    bank_b_valid,
  output logic [stripe_pkg::num_banks-1:0]                    bank_b_ready
);
  import stripe_pkg::*;

  logic                                  aw_fire;
  logic                                  b_fire;
  logic [num_banks-1:0]                  split_valid;
  logic [num_banks-1:0][bank_addr_w-1:0] split_addr;
  logic [num_banks-1:0][7:0]             split_len;
  bank_sel_t                             split_start;
  bank_sel_t                             split_end;
  axi_w_t                                sb_w;
  logic                                  sb_valid;
  logic                                  sb_ready;
  logic                                  w_active;
  bank_sel_t                             w_idx;
  logic [7:0]                            w_rem;
  logic                                  fwd;
  logic [num_banks-1:0]                  b_done;
  logic [num_banks-1:0]                  b_done_next;
  bank_sel_t                             end_idx;

  assign aw_fire = aw_valid && aw_ready;
  assign b_fire  = b_valid && b_ready;

  // ------------------------------
  // AW channel
  // ------------------------------

  stripe_addr_split u_addr_split (
    .addr      (aw.addr),
    .len       (aw.len),
    .start_idx (split_start),
    .end_idx   (split_end),
    .sub_valid (split_valid),
    .sub_addr  (split_addr),
    .sub_len   (split_len)
  );

  // only one write is in flight, so aw_ready stays low from the AW to the B
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      aw_ready      <= 1'b1;
      bank_aw_valid <= '0;
    end else begin
      bank_aw_valid <= bank_aw_valid & ~bank_aw_ready;
      if (aw_fire) begin
        aw_ready      <= 1'b0;
        bank_aw_valid <= split_valid;
      end else if (b_fire) begin
        aw_ready <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      end_idx <= split_end;
      for (int i = 0; i < num_banks; i++) begin
        bank_aw[i].id    <= aw.id;
        bank_aw[i].addr  <= split_addr[i];
        bank_aw[i].len   <= split_len[i];
        bank_aw[i].size  <= aw.size;
        bank_aw[i].burst <= aw.burst;
      end
    end
  end

  // ------------------------------
  // W channel
  // ------------------------------

  // beats may arrive ahead of their AW and wait here
  skid_buffer #(
    .payload_t (axi_w_t)
  ) u_w_skid (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (w_valid),
    .in_data   (w),
    .in_ready  (w_ready),
    .out_valid (sb_valid),
    .out_data  (sb_w),
    .out_ready (sb_ready)
  );

  // a beat moves on when its bank's W register is empty or draining
  assign fwd      = w_active && sb_valid && (!bank_w_valid[w_idx] || bank_w_ready[w_idx]);
  assign sb_ready = fwd;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_active     <= 1'b0;
      w_idx        <= '0;
      bank_w_valid <= '0;
    end else begin
      bank_w_valid <= bank_w_valid & ~bank_w_ready;
      if (aw_fire) begin
        w_active <= 1'b1;
        w_idx    <= split_start;
      end else if (fwd) begin
        bank_w_valid[w_idx] <= 1'b1;
        // num_banks is a power of two so the index simply wraps
        w_idx <= w_idx + 1'b1;
        if (w_rem == 8'd0) begin
          w_active <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      w_rem <= aw.len;
    end else if (fwd) begin
      w_rem <= w_rem - 8'd1;
      bank_w[w_idx].data <= sb_w.data;
      bank_w[w_idx].strb <= sb_w.strb;
      // no later beat of this burst comes back round to the same bank
      bank_w[w_idx].last <= w_rem < 8'(num_banks);
    end
  end

  // ------------------------------
  // B channel
  // ------------------------------

  // responses are always taken, so a fast bank never waits for a slow one
  assign bank_b_ready = '1;

  always_comb begin
    b_done_next = b_done;
    if (b_fire) begin
      b_done_next = '0;
    end
    // banks left out of the burst have nothing to answer
    if (aw_fire) begin
      b_done_next = ~split_valid;
    end
    b_done_next = b_done_next | (bank_b_valid & bank_b_ready);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      b_done  <= '0;
      b_valid <= 1'b0;
    end else begin
      b_done  <= b_done_next;
      b_valid <= &b_done_next;
    end
  end

  // the end bank took the final beat, so its answer stands for the burst
  always_ff @(posedge clk) begin
    if (bank_b_valid[end_idx] && bank_b_ready[end_idx]) begin
      b <= bank_b[end_idx];
    end
  end

  a_full_size : assert property (@(posedge clk) disable iff (!rst_n)
    aw_valid |-> aw.size == full_size);

  // the held response info would be overwritten by a second write
  a_no_b_at_aw : assert property (@(posedge clk) disable iff (!rst_n)
    aw_fire |-> !b_valid);

endmodule

// ==== design/stripe_bank.sv ====
`timescale 1ns/100ps

module stripe_bank (
  input  logic                              clk,
  input  logic                              rst_n,
  input  stripe_pkg::bank_aw_t              aw,
  input  logic                              aw_valid,
  output logic                              aw_ready,
  input  stripe_pkg::axi_w_t                w,
  input  logic                              w_valid,
  output logic                              w_ready,
  output stripe_pkg::axi_b_t                b,
  output logic                              b_valid,
  input  logic                              b_ready,
  input  logic                              rd_en,
  input  logic [stripe_pkg::bank_word_w-1:0] rd_addr,
  output logic [stripe_pkg::data_w-1:0]     rd_data
);
  import stripe_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_data,
    st_resp
  } state_t;

  state_t                 state;
  logic [bank_word_w-1:0] wr_addr;
  logic [7:0]             beat_cnt;
  logic [7:0]             len_q;
  logic                   err;
  logic                   w_fire;
  logic [data_w-1:0]      mem [bank_depth];

  // each handshake signal is just a decode of the state
  assign aw_ready = state == st_idle;
  assign w_ready  = state == st_data;
  assign b_valid  = state == st_resp;
  assign w_fire   = w_valid && w_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: if (aw_valid) state <= st_data;
        st_data: if (w_fire && beat_cnt == len_q) state <= st_resp;
        st_resp: if (b_ready) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_valid && aw_ready) begin
      wr_addr  <= aw.addr[bank_addr_w-1:word_off_w];
      len_q    <= aw.len;
      beat_cnt <= 8'd0;
      // anything but INCR is refused, its beats are drained and dropped
      err      <= aw.burst != burst_incr;
      b.id     <= aw.id;
      b.resp   <= (aw.burst == burst_incr) ? resp_okay : resp_slverr;
    end else if (w_fire) begin
      wr_addr  <= wr_addr + 1'b1;
      beat_cnt <= beat_cnt + 8'd1;
    end
  end

  // ------------------------------
  // storage
  // ------------------------------

  always_ff @(posedge clk) begin
    if (w_fire && !err) begin
      for (int i = 0; i < strb_w; i++) begin
        if (w.strb[i]) begin
          mem[wr_addr][i*8 +: 8] <= w.data[i*8 +: 8];
        end
      end
    end
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

  // the stripe engine's last flag has to agree with the sub-burst length
  a_last_matches_len : assert property (@(posedge clk) disable iff (!rst_n)
    w_fire |-> w.last == (beat_cnt == len_q));

endmodule

// ==== design/stripe_bank_array.sv ====
`timescale 1ns/100ps

module stripe_bank_array (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  stripe_pkg::bank_aw_t [stripe_pkg::num_banks-1:0]  aw,
  input  logic [stripe_pkg::num_banks-1:0]                  aw_valid,
  output logic [stripe_pkg::num_banks-1:0]                  aw_ready,
  input  stripe_pkg::axi_w_t [stripe_pkg::num_banks-1:0]    w,
  input  logic [stripe_pkg::num_banks-1:0]                  w_valid,
  output logic [stripe_pkg::num_banks-1:0]                  w_ready,
  output stripe_pkg::axi_b_t [stripe_pkg::num_banks-1:0]    b,
  output logic [stripe_pkg::num_banks-1:0]                  b_valid,
  input  logic [stripe_pkg::num_banks-1:0]                  b_ready,
  input  logic                                              rd_en,
  input  logic [stripe_pkg::word_idx_w-1:0]                 rd_addr,
  output logic [stripe_pkg::data_w-1:0]                     rd_data
);
  import stripe_pkg::*;

  logic [num_banks-1:0][data_w-1:0] bank_rd_data;
  bank_sel_t                        rd_sel;

  for (genvar i = 0; i < num_banks; i++) begin : gen_bank
    // every bank reads the same row, the select picks the column afterwards
    stripe_bank u_bank (
      .clk      (clk),
      .rst_n    (rst_n),
      .aw       (aw[i]),
      .aw_valid (aw_valid[i]),
      .aw_ready (aw_ready[i]),
      .w        (w[i]),
      .w_valid  (w_valid[i]),
      .w_ready  (w_ready[i]),
      .b        (b[i]),
      .b_valid  (b_valid[i]),
      .b_ready  (b_ready[i]),
      .rd_en    (rd_en),
      .rd_addr  (rd_addr[word_idx_w-1:bank_sel_w]),
      .rd_data  (bank_rd_data[i])
    );
  end

  // the select lines up with the bank read data one cycle later
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_sel <= rd_addr[bank_sel_w-1:0];
    end
  end

  assign rd_data = bank_rd_data[rd_sel];

endmodule

// ==== design/striped_mem_top.sv ====
`timescale 1ns/100ps

module striped_mem_top (
  input  logic                              clk,
  input  logic                              rst_n,
  input  stripe_pkg::axi_aw_t               aw,
  input  logic                              aw_valid,
  output logic                              aw_ready,
  input  stripe_pkg::axi_w_t                w,
  input  logic                              w_valid,
  output logic                              w_ready,
  output stripe_pkg::axi_b_t                b,
  output logic                              b_valid,
  input  logic                              b_ready,
  input  logic                              rd_en,
  input  logic [stripe_pkg::word_idx_w-1:0] rd_addr,
  output logic [stripe_pkg::data_w-1:0]     rd_data
);
  import stripe_pkg::*;

  // per-bank AXI write channels between the stripe engine and the banks
  bank_aw_t [num_banks-1:0] bank_aw;
  logic     [num_banks-1:0] bank_aw_valid;
  logic     [num_banks-1:0] bank_aw_ready;
  axi_w_t   [num_banks-1:0] bank_w;
  logic     [num_banks-1:0] bank_w_valid;
  logic     [num_banks-1:0] bank_w_ready;
  axi_b_t   [num_banks-1:0] bank_b;
  logic     [num_banks-1:0] bank_b_valid;
  logic     [num_banks-1:0] bank_b_ready;

  stripe_wr u_stripe_wr (
    .clk           (clk),
    .rst_n         (rst_n),
    .aw            (aw),
    .aw_valid      (aw_valid),
    .aw_ready      (aw_ready),
    .w             (w),
    .w_valid       (w_valid),
    .w_ready       (w_ready),
    .b             (b),
    .b_valid       (b_valid),
    .b_ready       (b_ready),
    .bank_aw       (bank_aw),
    .bank_aw_valid (bank_aw_valid),
    .bank_aw_ready (bank_aw_ready),
    .bank_w        (bank_w),
    .bank_w_valid  (bank_w_valid),
    .bank_w_ready  (bank_w_ready),
    .bank_b        (bank_b),
    .bank_b_valid  (bank_b_valid),
    .bank_b_ready  (bank_b_ready)
  );

  stripe_bank_array u_bank_array (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw       (bank_aw),
    .aw_valid (bank_aw_valid),
    .aw_ready (bank_aw_ready),
    .w        (bank_w),
    .w_valid  (bank_w_valid),
    .w_ready  (bank_w_ready),
    .b        (bank_b),
    .b_valid  (bank_b_valid),
    .b_ready  (bank_b_ready),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

endmodule

// ==== testbench/tb_striped_mem.sv ====
`timescale 1ns/100ps

module tb_striped_mem;
  import stripe_pkg::*;

  // longest wait allowed for any single handshake
  localparam int wait_limit = 1000;

  logic                  clk = 1'b0;
  logic                  rst_n;
  axi_aw_t               aw;
  logic                  aw_valid;
  logic                  aw_ready;
  axi_w_t                w;
  logic                  w_valid;
  logic                  w_ready;
  axi_b_t                b;
  logic                  b_valid;
  logic                  b_ready;
  logic                  rd_en;
  logic [word_idx_w-1:0] rd_addr;
  logic [data_w-1:0]     rd_data;

  // reference copy of the whole striped word space
  logic [data_w-1:0] model_mem [2**word_idx_w];

  int data_errs = 0;
  int resp_errs = 0;
  int proto_errs = 0;
  int timeouts = 0;

  always #2 clk = ~clk;

  striped_mem_top u_striped_mem_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .b        (b),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  // ------------------------------
  // reporting
  // ------------------------------

  task automatic finish_run();
    int total;
    total = data_errs + resp_errs + proto_errs + timeouts;
    $display("errors: %0d total, %0d data, %0d response, %0d protocol, %0d timeout",
             total, data_errs, resp_errs, proto_errs, timeouts);
    if (total == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  task automatic timed_out(input string what);
    timeouts++;
    $display("timeout while waiting for %s", what);
    finish_run();
  endtask

  task automatic check_resp(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      resp_errs++;
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_true(input logic ok, input string msg);
    assert (ok === 1'b1) else begin
      proto_errs++;
      $display("%s", msg);
    end
  endtask

  // ------------------------------
  // channel drivers
  // ------------------------------

  // every driver is entered on a falling edge and leaves on one
  task automatic send_aw(input axi_aw_t req, input int delay);
    int cnt;
    repeat (delay) @(negedge clk);
    aw       = req;
    aw_valid = 1'b1;
    cnt      = 0;
    // ready is a flop, so its value here decides the next rising edge
    while (!aw_ready && cnt < wait_limit) begin
      @(negedge clk);
      cnt++;
    end
    if (!aw_ready) timed_out("aw_ready");
    @(negedge clk);
    aw_valid = 1'b0;
    check_true(aw_ready === 1'b0, "aw_ready stayed high after an AW transfer");
  endtask

  task automatic send_w(input axi_w_t beats[$]);
    int gap;
    int cnt;
    foreach (beats[k]) begin
      // roughly one beat in four comes after an idle gap
      gap = ($urandom_range(0, 3) == 0) ? $urandom_range(1, 3) : 0;
      w_valid = 1'b0;
      repeat (gap) @(negedge clk);
      w       = beats[k];
      w_valid = 1'b1;
      cnt     = 0;
      while (!w_ready && cnt < wait_limit) begin
        @(negedge clk);
        cnt++;
      end
      if (!w_ready) timed_out("w_ready");
      @(negedge clk);
    end
    w_valid = 1'b0;
  endtask

  task automatic collect_b(input logic [id_w-1:0] exp_id, input logic [1:0] exp_resp);
    axi_b_t held;
    int     cnt;
    int     stall;
    cnt = 0;
    while (!b_valid && cnt < wait_limit) begin
      check_true(!aw_ready, "aw_ready rose before the B transfer");
      @(negedge clk);
      cnt++;
    end
    if (!b_valid) timed_out("b_valid");
    held = b;
    check_resp("b.id", held.id, exp_id);
    check_resp("b.resp", held.resp, exp_resp);
    // hold b_ready low for a while, the response must not move
    stall = $urandom_range(0, 4);
    repeat (stall) begin
      @(negedge clk);
      check_true(b_valid === 1'b1, "b_valid dropped while b_ready was low");
      check_true(b === held, "b changed while b_ready was low");
      check_true(aw_ready === 1'b0, "aw_ready rose while the B was stalled");
    end
    b_ready = 1'b1;
    @(negedge clk);
    b_ready = 1'b0;
    // a second B here would mean the burst was answered twice
    check_true(b_valid === 1'b0, "b_valid still high after the B transfer");
    check_true(aw_ready === 1'b1, "aw_ready did not return after the B transfer");
  endtask

  task automatic read_check(input int word);
    rd_en   = 1'b1;
    rd_addr = word_idx_w'(word);
    @(negedge clk);
    rd_en = 1'b0;
    // the data has to be there one cycle after the request
    assert (rd_data === model_mem[word]) else begin
      data_errs++;
      $display("ERROR rd_data at word 0x%h: got 0x%h, expected 0x%h",
               word, rd_data, model_mem[word]);
    end
    // no write is in flight during read-back, so any B now is a second answer
    check_true(b_valid === 1'b0, "b_valid rose with no burst in flight");
  endtask

  // ------------------------------
  // one complete burst
  // ------------------------------

  task automatic run_burst(input int start_word, input int len, input logic [1:0] kind,
                           input logic [id_w-1:0] id, input bit full_strb);
    axi_aw_t req;
    axi_w_t  beat;
    axi_w_t  beats[$];
    int      word;
    for (int k = 0; k <= len; k++) begin
      beat.data = $urandom;
      beat.strb = full_strb ? '1 : strb_w'($urandom);
      beat.last = (k == len);
      beats.push_back(beat);
    end
    req.id    = id;
    req.addr  = addr_w'(start_word << word_off_w);
    req.len   = 8'(len);
    req.size  = full_size;
    req.burst = kind;
    // the AW may lag the first W beats by a few cycles
    fork
      send_aw(req, $urandom_range(0, 3));
      send_w(beats);
    join
    collect_b(id, (kind == burst_incr) ? resp_okay : resp_slverr);
    // a refused burst leaves the model untouched
    if (kind == burst_incr) begin
      foreach (beats[k]) begin
        word = start_word + k;
        for (int i = 0; i < strb_w; i++) begin
          if (beats[k].strb[i]) begin
            model_mem[word][i*8 +: 8] = beats[k].data[i*8 +: 8];
          end
        end
      end
    end
    for (int k = 0; k <= len; k++) begin
      read_check(start_word + k);
    end
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial begin
    int         len;
    int         start;
    logic [1:0] kind;
    void'($urandom(26));
    rst_n    = 1'b0;
    aw       = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    rd_en    = 1'b0;
    rd_addr  = '0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_true(aw_ready === 1'b1, "aw_ready is not high after reset");
    check_true(b_valid === 1'b0, "b_valid is not low after reset");

    // fill every word once so later strobed writes merge onto known data
    for (int i = 0; i < 4; i++) begin
      run_burst(i * 256, 255, burst_incr, id_w'(i), 1'b1);
    end

    // a single beat starting in each bank
    for (int i = 0; i < num_banks; i++) begin
      run_burst(num_banks * $urandom_range(0, 255) + i, 0, burst_incr, id_w'($urandom), 1'b0);
    end

    // three stripe rounds starting in each bank
    for (int i = 0; i < num_banks; i++) begin
      run_burst(num_banks * $urandom_range(0, 250) + i, 11, burst_incr, id_w'($urandom),
                1'b0);
    end

    // random mix with about one FIXED burst in five
    for (int n = 0; n < 80; n++) begin
      len   = $urandom_range(0, 11);
      start = $urandom_range(0, 2**word_idx_w - 1 - len);
      kind  = ($urandom_range(0, 4) == 0) ? burst_fixed : burst_incr;
      run_burst(start, len, kind, id_w'($urandom), 1'b0);
    end

    finish_run();
  end

endmodule

// ==== sources.f ====
design/stripe_pkg.sv
design/skid_buffer.sv
design/stripe_addr_split.sv
design/stripe_wr.sv
design/stripe_bank.sv
design/stripe_bank_array.sv
design/striped_mem_top.sv
testbench/tb_striped_mem.sv

// ==== Bender.yml ====
package:
  name: striped_mem

sources:
  - design/stripe_pkg.sv
  - design/skid_buffer.sv
  - design/stripe_addr_split.sv
  - design/stripe_wr.sv
  - design/stripe_bank.sv
  - design/stripe_bank_array.sv
  - design/striped_mem_top.sv
  - target: test
    files:
      - testbench/tb_striped_mem.sv
